/* hdl/rotator_config.svh */
`ifndef ROTATOR_CONFIG_SVH
`define ROTATOR_CONFIG_SVH

// bits per weight lane
`define WR_LANE_WIDTH 8

// lanes carried side by side in one beat
`define WR_LANES 4

// kernel limits, both odd so that a half size exists
`define WR_KH_MAX 3
`define WR_KW_MAX 3

// input channels per set
`define WR_CIN_MAX 8

// image columns and row blocks
// a set is replayed once per column of each block
`define WR_COLS_MAX 4
`define WR_BLOCKS_MAX 4

`endif

/* hdl/rotator_pkg.sv */
`default_nettype none

`include "rotator_config.svh"

package rotator_pkg;

  localparam int BEAT_W   = `WR_LANE_WIDTH * `WR_LANES;

  // header field widths, each sized for its largest value
  localparam int KH2_W    = $clog2(`WR_KH_MAX / 2 + 1);
  localparam int KW2_W    = $clog2(`WR_KW_MAX / 2 + 1);
  localparam int CIN_W    = $clog2(`WR_CIN_MAX);
  localparam int COLS_W   = $clog2(`WR_COLS_MAX);
  localparam int BLOCKS_W = $clog2(`WR_BLOCKS_MAX);
  localparam int HDR_W    = BLOCKS_W + COLS_W + CIN_W + KH2_W + KW2_W;

  // kernel row counter runs from 2*kh2 down to 0
  localparam int KH_W     = KH2_W + 1;

  localparam int DEPTH    = `WR_KH_MAX * `WR_CIN_MAX;
  localparam int ADDR_W   = $clog2(DEPTH);

  typedef logic [BEAT_W-1:0]   beat_t;
  typedef logic [KH2_W-1:0]    kh2_t;
  typedef logic [KW2_W-1:0]    kw2_t;
  typedef logic [CIN_W-1:0]    cin_t;
  typedef logic [COLS_W-1:0]   cols_t;
  typedef logic [BLOCKS_W-1:0] blocks_t;
  typedef logic [ADDR_W-1:0]   addr_t;

  // sideband flags sent with every output beat
  typedef struct packed {
    logic is_cin_last;
    logic is_cols_1_k2;
    logic is_top_block;
    logic is_bottom_block;
    kw2_t kw2;
  } tuser_t;

  typedef enum logic [1:0] {LD_IDLE, LD_GET_HEADER, LD_WRITE, LD_SWITCH} load_state_e;
  typedef enum logic [1:0] {ROT_IDLE, ROT_READ, ROT_SWITCH} rot_state_e;

endpackage

`default_nettype wire

/* hdl/weight_loader.sv */
`default_nettype none

module weight_loader (
  input  wire logic                 aclk,
  input  wire logic                 i_reset,
  input  wire logic                 i_s_valid,
  input  wire rotator_pkg::beat_t   i_s_data,
  input  wire logic                 i_s_last,
  input  wire logic [1:0]           i_full,
  output logic                      o_s_ready,
  output logic                      o_hdr_we,
  output rotator_pkg::kw2_t         o_hdr_kw2,
  output rotator_pkg::kh2_t         o_hdr_kh2,
  output rotator_pkg::cin_t         o_hdr_cin_1,
  output rotator_pkg::cols_t        o_hdr_cols_1,
  output rotator_pkg::blocks_t      o_hdr_blocks_1,
  output logic                      o_wr_en,
  output rotator_pkg::addr_t        o_wr_addr,
  output rotator_pkg::beat_t        o_wr_data,
  output logic                      o_fill_done,
  output logic                      o_bank_sel
);

  rotator_pkg::load_state_e state, state_next;
  logic                     handshake;

  assign handshake = i_s_valid && o_s_ready;

  // header fields sit in the low bits of the first beat, kw2 lowest
  assign {o_hdr_blocks_1, o_hdr_cols_1, o_hdr_cin_1, o_hdr_kh2, o_hdr_kw2} =
    i_s_data[rotator_pkg::HDR_W-1:0];

  assign o_hdr_we    = handshake && (state == rotator_pkg::LD_GET_HEADER);
  assign o_wr_en     = handshake && (state == rotator_pkg::LD_WRITE);
  assign o_wr_data   = i_s_data;
  assign o_fill_done = state == rotator_pkg::LD_SWITCH;

  always_comb begin
    state_next = state;
    unique case (state)
      rotator_pkg::LD_IDLE: begin
        // never touch a bank that still waits to be drained
        if (!i_full[o_bank_sel]) state_next = rotator_pkg::LD_GET_HEADER;
      end
      rotator_pkg::LD_GET_HEADER: begin
        if (handshake) state_next = rotator_pkg::LD_WRITE;
      end
      rotator_pkg::LD_WRITE: begin
        if (handshake && i_s_last) state_next = rotator_pkg::LD_SWITCH;
      end
      rotator_pkg::LD_SWITCH: begin
        state_next = rotator_pkg::LD_IDLE;
      end
      default: state_next = rotator_pkg::LD_IDLE;
    endcase
  end

  always_ff @(posedge aclk) begin
    if (i_reset) begin
      state      <= rotator_pkg::LD_IDLE;
      o_s_ready  <= 1'b0;
      o_bank_sel <= 1'b0;
      o_wr_addr  <= '0;
    end else begin
      state <= state_next;
      // ready rises one cycle into GET_HEADER and holds through WRITE
      o_s_ready <= (state_next == rotator_pkg::LD_WRITE) ||
                   (state == rotator_pkg::LD_GET_HEADER &&
                    state_next == rotator_pkg::LD_GET_HEADER);
      if (state == rotator_pkg::LD_SWITCH) o_bank_sel <= !o_bank_sel;
      if (state == rotator_pkg::LD_GET_HEADER) begin
        o_wr_addr <= '0;
      end else if (o_wr_en) begin
        o_wr_addr <= o_wr_addr + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/weight_bank.sv */
`default_nettype none

module weight_bank (
  input  wire logic                 aclk,
  input  wire logic                 i_reset,
  input  wire logic                 i_sel,
  input  wire logic                 i_hdr_we,
  input  wire rotator_pkg::kw2_t    i_hdr_kw2,
  input  wire rotator_pkg::kh2_t    i_hdr_kh2,
  input  wire rotator_pkg::cin_t    i_hdr_cin_1,
  input  wire rotator_pkg::cols_t   i_hdr_cols_1,
  input  wire rotator_pkg::blocks_t i_hdr_blocks_1,
  input  wire logic                 i_wr_en,
  input  wire rotator_pkg::addr_t   i_wr_addr,
  input  wire rotator_pkg::beat_t   i_wr_data,
  input  wire logic                 i_fill_done,
  input  wire rotator_pkg::addr_t   i_rd_addr,
  input  wire logic                 i_drain_done,
  output rotator_pkg::beat_t        o_rd_data,
  output logic                      o_full,
  output rotator_pkg::kh2_t         o_kh2,
  output rotator_pkg::kw2_t         o_kw2,
  output rotator_pkg::cin_t         o_cin_1,
  output rotator_pkg::cols_t        o_cols_1,
  output rotator_pkg::blocks_t      o_blocks_1
);

  rotator_pkg::beat_t mem [rotator_pkg::DEPTH];

  // one write port, registered read
  always_ff @(posedge aclk) begin
    if (i_sel && i_wr_en) mem[i_wr_addr] <= i_wr_data;
    o_rd_data <= mem[i_rd_addr];
  end

  // shape of the set held in this bank
  always_ff @(posedge aclk) begin
    if (i_sel && i_hdr_we) begin
      o_kh2      <= i_hdr_kh2;
      o_kw2      <= i_hdr_kw2;
      o_cin_1    <= i_hdr_cin_1;
      o_cols_1   <= i_hdr_cols_1;
      o_blocks_1 <= i_hdr_blocks_1;
    end
  end

  // set once the loader finishes, cleared once the sequencer is done
  always_ff @(posedge aclk) begin
    if (i_reset) begin
      o_full <= 1'b0;
    end else if (i_sel && i_fill_done) begin
      o_full <= 1'b1;
    end else if (i_drain_done) begin
      o_full <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* hdl/rotation_sequencer.sv */
`default_nettype none

module rotation_sequencer (
  input  wire logic                 aclk,
  input  wire logic                 i_reset,
  input  wire logic [1:0]           i_full,
  input  wire rotator_pkg::kh2_t    i_kh2 [2],
  input  wire rotator_pkg::kw2_t    i_kw2 [2],
  input  wire rotator_pkg::cin_t    i_cin_1 [2],
  input  wire rotator_pkg::cols_t   i_cols_1 [2],
  input  wire rotator_pkg::blocks_t i_blocks_1 [2],
  input  wire rotator_pkg::beat_t   i_rd_data [2],
  input  wire logic                 i_m_ready,
  output rotator_pkg::addr_t        o_rd_addr,
  output logic                      o_drain_done,
  output logic                      o_bank_sel,
  output logic                      o_m_valid,
  output rotator_pkg::beat_t        o_m_data,
  output logic                      o_m_last,
  output rotator_pkg::tuser_t       o_m_user
);

  rotator_pkg::rot_state_e      state, state_next;
  logic [rotator_pkg::KH_W-1:0] count_kh, top_kh;
  rotator_pkg::cin_t            count_cin;
  rotator_pkg::cols_t           count_cols;
  rotator_pkg::blocks_t         count_blocks;
  rotator_pkg::addr_t           addr, addr_next;
  logic                         last_kh, last_cin, last_cols, last_blocks;
  logic                         handshake;

  // kernel height minus one
  assign top_kh = {i_kh2[o_bank_sel], 1'b0};

  assign last_kh     = count_kh == '0;
  assign last_cin    = count_cin == '0;
  assign last_cols   = count_cols == '0;
  assign last_blocks = count_blocks == '0;

  assign o_m_valid    = state == rotator_pkg::ROT_READ;
  assign o_drain_done = state == rotator_pkg::ROT_SWITCH;
  assign handshake    = o_m_valid && i_m_ready;

  // each pass of kh*cin beats starts again at address zero
  assign addr_next = (last_kh && last_cin) ? '0 : addr + 1'b1;
  // stalled beats re-read their own address
  assign o_rd_addr = handshake ? addr_next : addr;

  assign o_m_data = i_rd_data[o_bank_sel];
  assign o_m_last = last_kh && last_cin && last_cols && last_blocks;

  assign o_m_user.is_cin_last     = last_kh && last_cin;
  // cols-1-c == kw2, with count_cols holding cols-1-c
  assign o_m_user.is_cols_1_k2    = count_cols == rotator_pkg::cols_t'(i_kw2[o_bank_sel]);
  assign o_m_user.is_top_block    = count_blocks == i_blocks_1[o_bank_sel];
  assign o_m_user.is_bottom_block = last_blocks;
  assign o_m_user.kw2             = i_kw2[o_bank_sel];

  always_comb begin
    state_next = state;
    unique case (state)
      rotator_pkg::ROT_IDLE: begin
        if (i_full[o_bank_sel]) state_next = rotator_pkg::ROT_READ;
      end
      rotator_pkg::ROT_READ: begin
        if (handshake && o_m_last) state_next = rotator_pkg::ROT_SWITCH;
      end
      rotator_pkg::ROT_SWITCH: begin
        state_next = rotator_pkg::ROT_IDLE;
      end
      default: state_next = rotator_pkg::ROT_IDLE;
    endcase
  end

  always_ff @(posedge aclk) begin
    if (i_reset) begin
      state      <= rotator_pkg::ROT_IDLE;
      o_bank_sel <= 1'b0;
      addr       <= '0;
    end else begin
      state <= state_next;
      if (state == rotator_pkg::ROT_SWITCH) o_bank_sel <= !o_bank_sel;
      if (handshake) addr <= addr_next;
    end
  end

  // nested down-counters, kh innermost, then cin, cols, blocks
  always_ff @(posedge aclk) begin
    if (i_reset) begin
      count_kh     <= '0;
      count_cin    <= '0;
      count_cols   <= '0;
      count_blocks <= '0;
    end else if (state == rotator_pkg::ROT_IDLE) begin
      count_kh     <= top_kh;
      count_cin    <= i_cin_1[o_bank_sel];
      count_cols   <= i_cols_1[o_bank_sel];
      count_blocks <= i_blocks_1[o_bank_sel];
    end else if (handshake) begin
      count_kh <= last_kh ? top_kh : count_kh - 1'b1;
      if (last_kh) begin
        count_cin <= last_cin ? i_cin_1[o_bank_sel] : count_cin - 1'b1;
        if (last_cin) begin
          count_cols <= last_cols ? i_cols_1[o_bank_sel] : count_cols - 1'b1;
          if (last_cols) begin
            count_blocks <= last_blocks ? i_blocks_1[o_bank_sel] : count_blocks - 1'b1;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/weight_rotator.sv */
`default_nettype none

module weight_rotator (
  input  wire logic                aclk,
  input  wire logic                i_reset,
  input  wire logic                i_s_valid,
  output logic                     o_s_ready,
  input  wire rotator_pkg::beat_t  i_s_data,
  input  wire logic                i_s_last,
  output logic                     o_m_valid,
  input  wire logic                i_m_ready,
  output rotator_pkg::beat_t       o_m_data,
  output logic                     o_m_last,
  output rotator_pkg::tuser_t      o_m_user
);

  // loader to banks
  logic                 ld_hdr_we, ld_wr_en, ld_fill_done, ld_bank;
  rotator_pkg::kw2_t    ld_kw2;
  rotator_pkg::kh2_t    ld_kh2;
  rotator_pkg::cin_t    ld_cin_1;
  rotator_pkg::cols_t   ld_cols_1;
  rotator_pkg::blocks_t ld_blocks_1;
  rotator_pkg::addr_t   ld_wr_addr;
  rotator_pkg::beat_t   ld_wr_data;

  // sequencer to banks
  rotator_pkg::addr_t   rd_addr;
  logic                 rd_drain_done, rd_bank;

  // per bank state
  logic [1:0]           bank_full;
  rotator_pkg::beat_t   bank_data [2];
  rotator_pkg::kh2_t    bank_kh2 [2];
  rotator_pkg::kw2_t    bank_kw2 [2];
  rotator_pkg::cin_t    bank_cin_1 [2];
  rotator_pkg::cols_t   bank_cols_1 [2];
  rotator_pkg::blocks_t bank_blocks_1 [2];

  weight_loader u_loader (
    .aclk(aclk), .i_reset(i_reset),
    .i_s_valid(i_s_valid), .i_s_data(i_s_data), .i_s_last(i_s_last), .i_full(bank_full),
    .o_s_ready(o_s_ready), .o_hdr_we(ld_hdr_we),
    .o_hdr_kw2(ld_kw2), .o_hdr_kh2(ld_kh2), .o_hdr_cin_1(ld_cin_1),
    .o_hdr_cols_1(ld_cols_1), .o_hdr_blocks_1(ld_blocks_1),
    .o_wr_en(ld_wr_en), .o_wr_addr(ld_wr_addr), .o_wr_data(ld_wr_data),
    .o_fill_done(ld_fill_done), .o_bank_sel(ld_bank)
  );

  for (genvar i = 0; i < 2; i++) begin : g_bank
    weight_bank u_bank (
      .aclk(aclk), .i_reset(i_reset), .i_sel(ld_bank == 1'(i)), .i_hdr_we(ld_hdr_we),
      .i_hdr_kw2(ld_kw2), .i_hdr_kh2(ld_kh2), .i_hdr_cin_1(ld_cin_1),
      .i_hdr_cols_1(ld_cols_1), .i_hdr_blocks_1(ld_blocks_1),
      .i_wr_en(ld_wr_en), .i_wr_addr(ld_wr_addr), .i_wr_data(ld_wr_data),
      .i_fill_done(ld_fill_done), .i_rd_addr(rd_addr),
      .i_drain_done(rd_drain_done && rd_bank == 1'(i)),
      .o_rd_data(bank_data[i]), .o_full(bank_full[i]),
      .o_kh2(bank_kh2[i]), .o_kw2(bank_kw2[i]), .o_cin_1(bank_cin_1[i]),
      .o_cols_1(bank_cols_1[i]), .o_blocks_1(bank_blocks_1[i])
    );
  end

  rotation_sequencer u_sequencer (
    .aclk(aclk), .i_reset(i_reset), .i_full(bank_full),
    .i_kh2(bank_kh2), .i_kw2(bank_kw2), .i_cin_1(bank_cin_1),
    .i_cols_1(bank_cols_1), .i_blocks_1(bank_blocks_1), .i_rd_data(bank_data),
    .i_m_ready(i_m_ready), .o_rd_addr(rd_addr), .o_drain_done(rd_drain_done),
    .o_bank_sel(rd_bank), .o_m_valid(o_m_valid), .o_m_data(o_m_data),
    .o_m_last(o_m_last), .o_m_user(o_m_user)
  );

endmodule

`default_nettype wire

/* test/rotator_model.sv */
`default_nettype none

package rotator_model;

  timeunit 1ns;
  timeprecision 1ps;

  typedef struct packed {
    rotator_pkg::beat_t  data;
    logic                last;
    rotator_pkg::tuser_t user;
  } beat_exp_t;

  // expected output beats, oldest first
  beat_exp_t expected [$];

  // c counts columns up from 0 inside a block, b counts blocks
  function automatic rotator_pkg::tuser_t flags_for(input logic pass_end, input int cols,
                                                    input int blocks, input int kw2,
                                                    input int c, input int b);
    rotator_pkg::tuser_t u;
    u.is_cin_last     = pass_end;
    u.is_cols_1_k2    = (cols - 1 - c) == kw2;
    u.is_top_block    = b == 0;
    u.is_bottom_block = b == blocks - 1;
    u.kw2             = rotator_pkg::kw2_t'(kw2);
    return u;
  endfunction

  // one set replays its stored beats once per column of every block
  function automatic void push_set(input int kw2, input int cols, input int blocks,
                                   input rotator_pkg::beat_t weights [$]);
    beat_exp_t e;
    int        n;
    n = weights.size();
    for (int b = 0; b < blocks; b++) begin
      for (int c = 0; c < cols; c++) begin
        for (int i = 0; i < n; i++) begin
          e.data = weights[i];
          e.last = (b == blocks - 1) && (c == cols - 1) && (i == n - 1);
          e.user = flags_for(i == n - 1, cols, blocks, kw2, c, b);
          expected.push_back(e);
        end
      end
    end
  endfunction

endpackage

`default_nettype wire

/* test/tb_weight_rotator.sv */
`default_nettype none

`include "rotator_config.svh"

module tb_weight_rotator;

  timeunit 1ns;
  timeprecision 1ps;

  // worst case cycles for one set, output beats plus gapped input beats
  localparam int SET_CYCLES   = `WR_KH_MAX * `WR_CIN_MAX * `WR_COLS_MAX * `WR_BLOCKS_MAX +
                                4 * (`WR_KH_MAX * `WR_CIN_MAX + 1) + 30;
  localparam int TOTAL_SETS   = 13;
  localparam int STALL_MARGIN = 4;

  logic                     aclk, i_reset, i_s_valid, o_s_ready, i_s_last;
  logic                     o_m_valid, i_m_ready, o_m_last;
  rotator_pkg::beat_t       i_s_data, o_m_data, held_data;
  rotator_pkg::tuser_t      o_m_user, held_user;
  logic                     ready_random, holding, held_last;
  int                       errors, checks, tests_run, tests_failed, got_beats;
  rotator_model::beat_exp_t exp_beat;

  weight_rotator u_weight_rotator (
    .aclk(aclk), .i_reset(i_reset),
    .i_s_valid(i_s_valid), .o_s_ready(o_s_ready), .i_s_data(i_s_data), .i_s_last(i_s_last),
    .o_m_valid(o_m_valid), .i_m_ready(i_m_ready), .o_m_data(o_m_data),
    .o_m_last(o_m_last), .o_m_user(o_m_user)
  );

  initial begin
    aclk = 1'b0;
    forever #5 aclk = ~aclk;
  end

  // entered on a falling edge, returns on the falling edge after the handshake
  task automatic send_beat(input rotator_pkg::beat_t data, input logic last);
    i_s_valid = 1'b1;
    i_s_data  = data;
    i_s_last  = last;
    while (!o_s_ready) @(negedge aclk);
    @(negedge aclk);
    i_s_valid = 1'b0;
  endtask

  task automatic input_gap(input logic gaps);
    if (gaps) repeat ($urandom_range(3)) @(negedge aclk);
  endtask

  task automatic send_set(input logic zero_shape, input logic gaps, output int beats);
    rotator_pkg::kw2_t    kw2;
    rotator_pkg::kh2_t    kh2;
    rotator_pkg::cin_t    cin_1;
    rotator_pkg::cols_t   cols_1;
    rotator_pkg::blocks_t blocks_1;
    rotator_pkg::beat_t   hdr;
    rotator_pkg::beat_t   weights [$];
    int                   n;
    kw2      = rotator_pkg::kw2_t'($urandom_range(`WR_KW_MAX / 2));
    kh2      = rotator_pkg::kh2_t'($urandom_range(`WR_KH_MAX / 2));
    cin_1    = rotator_pkg::cin_t'($urandom_range(`WR_CIN_MAX - 1));
    cols_1   = rotator_pkg::cols_t'($urandom_range(`WR_COLS_MAX - 1));
    blocks_1 = rotator_pkg::blocks_t'($urandom_range(`WR_BLOCKS_MAX - 1));
    if (zero_shape) {kw2, kh2, cin_1, cols_1, blocks_1} = '0;
    // bits above the header are don't care
    hdr = rotator_pkg::beat_t'($urandom);
    hdr[rotator_pkg::HDR_W-1:0] = {blocks_1, cols_1, cin_1, kh2, kw2};
    n = (2 * int'(kh2) + 1) * (int'(cin_1) + 1);
    send_beat(hdr, 1'b0);
    for (int i = 0; i < n; i++) begin
      input_gap(gaps);
      weights.push_back(rotator_pkg::beat_t'($urandom));
      send_beat(weights[i], i == n - 1);
    end
    // tlast accepted, the set's output is now expected
    rotator_model::push_set(int'(kw2), int'(cols_1) + 1, int'(blocks_1) + 1, weights);
    beats = n * (int'(cols_1) + 1) * (int'(blocks_1) + 1);
  endtask

  task automatic run_test(input string name, input int sets, input logic zero_shape,
                          input logic stall, input logic gaps);
    int start_errors;
    int expect_beats;
    int n;
    start_errors = errors;
    expect_beats = 0;
    got_beats    = 0;
    ready_random = stall;
    for (int s = 0; s < sets; s++) begin
      send_set(zero_shape, gaps, n);
      expect_beats += n;
      input_gap(gaps);
    end
    while (rotator_model::expected.size() != 0) @(negedge aclk);
    // room for a stray beat past the end of the set
    repeat (20) @(negedge aclk);
    if (got_beats != expect_beats) begin
      errors++;
      $display("error: output beat count got %h expected %h", got_beats, expect_beats);
    end
    tests_run++;
    if (errors != start_errors) tests_failed++;
    $display("test %s: %s", name, (errors == start_errors) ? "ok" : "failed");
  endtask

  // output side, ready driven and beat checked on the falling edge
  initial begin
    i_m_ready = 1'b0;
    holding   = 1'b0;
    forever begin
      @(negedge aclk);
      i_m_ready = ready_random ? ($urandom_range(99) < 60) : 1'b1;
      if (o_m_valid && holding &&
          {o_m_data, o_m_last, o_m_user} !== {held_data, held_last, held_user}) begin
        errors++;
        $display("error: stalled o_m_data %h o_m_last %h o_m_user %h, held %h %h %h",
                 o_m_data, o_m_last, o_m_user, held_data, held_last, held_user);
      end
      if (o_m_valid && i_m_ready) begin
        holding = 1'b0;
        got_beats++;
        if (rotator_model::expected.size() == 0) begin
          errors++;
          $display("an output beat came out while no beat was expected");
        end else begin
          exp_beat = rotator_model::expected.pop_front();
          checks++;
          if ({o_m_data, o_m_last, o_m_user} !== exp_beat) begin
            errors++;
            $display("error: o_m_data %h o_m_last %h o_m_user %h, expected %h %h %h",
                     o_m_data, o_m_last, o_m_user, exp_beat.data, exp_beat.last,
                     exp_beat.user);
          end
        end
      end else if (o_m_valid && !holding) begin
        holding   = 1'b1;
        held_data = o_m_data;
        held_last = o_m_last;
        held_user = o_m_user;
      end
    end
  end

  initial begin
    #(TOTAL_SETS * SET_CYCLES * STALL_MARGIN * 10);
    $display("timeout: the sets did not drain within the time limit");
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    void'($urandom(90840));
    errors       = 0;
    checks       = 0;
    tests_run    = 0;
    tests_failed = 0;
    got_beats    = 0;
    ready_random = 1'b0;
    i_reset      = 1'b1;
    i_s_valid    = 1'b0;
    i_s_data     = '0;
    i_s_last     = 1'b0;
    repeat (10) @(negedge aclk);
    if (o_s_ready || o_m_valid) begin
      errors++;
      $display("stream ready or valid was high during reset");
    end
    i_reset = 1'b0;
    run_test("rotation order", 1, 1'b0, 1'b0, 1'b0);
    run_test("last and count", 1, 1'b0, 1'b0, 1'b0);
    run_test("flags", 2, 1'b0, 1'b0, 1'b0);
    run_test("output back-pressure", 2, 1'b0, 1'b1, 1'b0);
    run_test("ping-pong", 6, 1'b0, 1'b1, 1'b1);
    run_test("minimum shape", 1, 1'b1, 1'b0, 1'b0);
    $display("tests %0d, failed %0d, beats checked %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+hdl
hdl/rotator_pkg.sv
hdl/weight_loader.sv
hdl/weight_bank.sv
hdl/rotation_sequencer.sv
hdl/weight_rotator.sv
test/rotator_model.sv
test/tb_weight_rotator.sv

/* Makefile */
# Verilator build and run for the weight rotator testbench

VERILATOR ?= verilator
TOP       ?= tb_weight_rotator
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timescale 1ns/1ps
PASS_MSG  ?= TESTBENCH PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
